// File: rtl/mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// memory bus widths
`define MEM_ADDR_W 64
`define MEM_DATA_W 64

// transaction tags with zero never handed out
`define MEM_TAG_W 4
`define NUM_TAGS 16

// pending requests per client queue
`define MISS_DEPTH 4

`endif

// File: rtl/mem_pkg.sv
`include "mem_cfg.svh"

package mem_pkg;

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_e;

  typedef logic [`MEM_TAG_W-1:0] mem_tag_t; // 0 means no tag

  typedef enum logic {
    OWNER_I = 1'b0,
    OWNER_D = 1'b1
  } owner_e;

  // client strobes
  typedef struct packed {
    logic                   valid;
    logic [`MEM_ADDR_W-1:0] addr;
  } i_req_t;

  typedef struct packed {
    logic                   valid;
    bus_cmd_e               cmd;   // load or store
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] data;  // store data only
  } d_req_t;

  // queued forms carry no valid bit
  typedef struct packed {
    logic [`MEM_ADDR_W-1:0] addr;
  } i_miss_t;

  typedef struct packed {
    bus_cmd_e               cmd;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] data;
  } d_miss_t;

  typedef struct packed {
    logic                   valid; // one-cycle pulse
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] data;
  } mem_rsp_t;

endpackage

// File: rtl/req_queue.sv
`include "mem_cfg.svh"

module req_queue #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = `MISS_DEPTH
) (
  input  logic     clock,
  input  logic     rst,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     not_empty,
  output logic     full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         entries [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push && !full;     // push while full is dropped
  assign do_pop  = pop && not_empty;

  assign head      = entries[rd_ptr];
  assign not_empty = (count != '0);
  assign full      = (count == CNT_W'(DEPTH));

  always_ff @(posedge clock) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // entry storage
  always_ff @(posedge clock) begin
    if (do_push) begin
      entries[wr_ptr] <= push_data;
    end
  end

endmodule

// File: rtl/bus_arbiter.sv
`include "mem_cfg.svh"

module bus_arbiter (
  input  mem_pkg::i_miss_t         i_head,
  input  logic                     i_ready,
  input  mem_pkg::d_miss_t         d_head,
  input  logic                     d_ready,
  input  mem_pkg::mem_tag_t        mem2proc_response,
  output mem_pkg::bus_cmd_e        proc2mem_command,
  output logic [`MEM_ADDR_W-1:0]   proc2mem_addr,
  output logic [`MEM_DATA_W-1:0]   proc2mem_data,
  output logic                     i_pop,
  output logic                     d_pop,
  output logic                     alloc,
  output mem_pkg::mem_tag_t        alloc_tag,
  output mem_pkg::owner_e          alloc_owner,
  output logic [`MEM_ADDR_W-1:0]   alloc_addr
);

  import mem_pkg::*;

  logic accept;

  // data side always wins the bus when it has something queued
  always_comb begin
    proc2mem_command = BUS_NONE;
    proc2mem_addr    = '0;
    proc2mem_data    = '0;
    if (d_ready) begin
      proc2mem_command = d_head.cmd;
      proc2mem_addr    = d_head.addr;
      proc2mem_data    = d_head.data;
    end else if (i_ready) begin
      proc2mem_command = BUS_LOAD;   // fetches are always reads
      proc2mem_addr    = i_head.addr;
    end
  end

  // nonzero response tag means memory took it
  assign accept = (mem2proc_response != '0) && (proc2mem_command != BUS_NONE);

  assign d_pop = accept && d_ready;
  assign i_pop = accept && !d_ready;

  // stores return nothing, so only loads hold a tag
  assign alloc       = accept && (proc2mem_command == BUS_LOAD);
  assign alloc_tag   = mem2proc_response;
  assign alloc_owner = d_ready ? OWNER_D : OWNER_I;
  assign alloc_addr  = proc2mem_addr;

endmodule

// File: rtl/tag_table.sv
`include "mem_cfg.svh"

module tag_table (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   alloc,
  input  mem_pkg::mem_tag_t      alloc_tag,
  input  mem_pkg::owner_e        alloc_owner,
  input  logic [`MEM_ADDR_W-1:0] alloc_addr,
  input  mem_pkg::mem_tag_t      mem2proc_tag,
  input  logic [`MEM_DATA_W-1:0] mem2proc_data,
  output mem_pkg::mem_rsp_t      i_rsp,
  output mem_pkg::mem_rsp_t      d_rsp
);

  import mem_pkg::*;

  logic [`NUM_TAGS-1:0]   entry_valid;
  owner_e                 entry_owner [`NUM_TAGS];
  logic [`MEM_ADDR_W-1:0] entry_addr  [`NUM_TAGS];
  logic                   hit;
  logic                   i_rsp_valid;
  logic                   d_rsp_valid;
  logic [`MEM_ADDR_W-1:0] rsp_addr;   // shared by both channels
  logic [`MEM_DATA_W-1:0] rsp_data;

  // tag zero and stale tags are ignored
  assign hit = (mem2proc_tag != '0) && entry_valid[mem2proc_tag];

  always_ff @(posedge clock) begin
    if (rst) begin
      entry_valid <= '0;
      i_rsp_valid <= 1'b0;
      d_rsp_valid <= 1'b0;
    end else begin
      i_rsp_valid <= hit && (entry_owner[mem2proc_tag] == OWNER_I);
      d_rsp_valid <= hit && (entry_owner[mem2proc_tag] == OWNER_D);
      if (hit) begin
        entry_valid[mem2proc_tag] <= 1'b0;
      end
      if (alloc) begin
        entry_valid[alloc_tag] <= 1'b1;  // reuse of a freed tag wins
      end
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      entry_owner[alloc_tag] <= alloc_owner;
      entry_addr[alloc_tag]  <= alloc_addr;
    end
    if (hit) begin
      rsp_addr <= entry_addr[mem2proc_tag];
      rsp_data <= mem2proc_data;
    end
  end

  assign i_rsp = '{valid: i_rsp_valid, addr: rsp_addr, data: rsp_data};
  assign d_rsp = '{valid: d_rsp_valid, addr: rsp_addr, data: rsp_data};

endmodule

// File: rtl/mem_port.sv
`include "mem_cfg.svh"

module mem_port (
  input  logic                   clock,
  input  logic                   rst,
  input  mem_pkg::i_req_t        i_req,
  input  mem_pkg::d_req_t        d_req,
  output logic                   i_full,
  output logic                   d_full,
  output mem_pkg::mem_rsp_t      i_rsp,
  output mem_pkg::mem_rsp_t      d_rsp,
  output mem_pkg::bus_cmd_e      proc2mem_command,
  output logic [`MEM_ADDR_W-1:0] proc2mem_addr,
  output logic [`MEM_DATA_W-1:0] proc2mem_data,
  input  mem_pkg::mem_tag_t      mem2proc_response,
  input  logic [`MEM_DATA_W-1:0] mem2proc_data,
  input  mem_pkg::mem_tag_t      mem2proc_tag
);

  import mem_pkg::*;

  i_miss_t                i_push_data;
  d_miss_t                d_push_data;
  i_miss_t                i_head;
  d_miss_t                d_head;
  logic                   i_ready;
  logic                   d_ready;
  logic                   i_pop;
  logic                   d_pop;
  logic                   alloc;
  mem_tag_t               alloc_tag;
  owner_e                 alloc_owner;
  logic [`MEM_ADDR_W-1:0] alloc_addr;

  // valid becomes the push strobe
  assign i_push_data = '{addr: i_req.addr};
  assign d_push_data = '{cmd: d_req.cmd, addr: d_req.addr, data: d_req.data};

  req_queue #(.payload_t(i_miss_t), .DEPTH(`MISS_DEPTH)) i_queue (
    .clock     (clock),
    .rst       (rst),
    .push      (i_req.valid),
    .push_data (i_push_data),
    .pop       (i_pop),
    .head      (i_head),
    .not_empty (i_ready),
    .full      (i_full)
  );

  req_queue #(.payload_t(d_miss_t), .DEPTH(`MISS_DEPTH)) d_queue (
    .clock     (clock),
    .rst       (rst),
    .push      (d_req.valid),
    .push_data (d_push_data),
    .pop       (d_pop),
    .head      (d_head),
    .not_empty (d_ready),
    .full      (d_full)
  );

  bus_arbiter arbiter (
    .i_head            (i_head),
    .i_ready           (i_ready),
    .d_head            (d_head),
    .d_ready           (d_ready),
    .mem2proc_response (mem2proc_response),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data),
    .i_pop             (i_pop),
    .d_pop             (d_pop),
    .alloc             (alloc),
    .alloc_tag         (alloc_tag),
    .alloc_owner       (alloc_owner),
    .alloc_addr        (alloc_addr)
  );

  tag_table tags (
    .clock         (clock),
    .rst           (rst),
    .alloc         (alloc),
    .alloc_tag     (alloc_tag),
    .alloc_owner   (alloc_owner),
    .alloc_addr    (alloc_addr),
    .mem2proc_tag  (mem2proc_tag),
    .mem2proc_data (mem2proc_data),
    .i_rsp         (i_rsp),
    .d_rsp         (d_rsp)
  );

endmodule

// File: dv/mem_port_assertions.sv
`include "mem_cfg.svh"

module mem_port_assertions (
  input logic                   clock,
  input logic                   rst,
  input mem_pkg::i_req_t        i_req,
  input mem_pkg::d_req_t        d_req,
  input logic                   i_full,
  input logic                   d_full,
  input logic                   d_ready,
  input mem_pkg::mem_rsp_t      i_rsp,
  input mem_pkg::mem_rsp_t      d_rsp,
  input mem_pkg::bus_cmd_e      proc2mem_command,
  input logic [`MEM_ADDR_W-1:0] proc2mem_addr,
  input logic [`MEM_DATA_W-1:0] proc2mem_data,
  input mem_pkg::mem_tag_t      mem2proc_response,
  input mem_pkg::mem_tag_t      mem2proc_tag
);
  timeunit 1ns;
  timeprecision 100ps;

  import mem_pkg::*;

  localparam int CNT_W = $clog2(`MISS_DEPTH + 1);

  logic [CNT_W-1:0]     d_pending;  // data strobes not yet accepted
  logic                 d_accept;
  logic [`NUM_TAGS-1:0] load_tags;  // loads that memory still owes
  logic                 reply_hit;

  // while data is pending every accept belongs to the data side
  assign d_accept  = (mem2proc_response != '0) && (proc2mem_command != BUS_NONE) &&
                     (d_pending != '0);
  assign reply_hit = (mem2proc_tag != '0) && load_tags[mem2proc_tag];

  always_ff @(posedge clock) begin
    if (rst) begin
      d_pending <= '0;
      load_tags <= '0;
    end else begin
      d_pending <= d_pending + CNT_W'(d_req.valid && !d_full) - CNT_W'(d_accept);
      if (reply_hit) begin
        load_tags[mem2proc_tag] <= 1'b0;
      end
      if (mem2proc_response != '0 && proc2mem_command == BUS_LOAD) begin
        load_tags[mem2proc_response] <= 1'b1;
      end
    end
  end

  no_i_push_full: assert property (@(posedge clock) disable iff (rst)
    i_req.valid |-> !i_full) else $error("instruction strobe while i_full");

  no_d_push_full: assert property (@(posedge clock) disable iff (rst)
    d_req.valid |-> !d_full) else $error("data strobe while d_full");

  // a stall holds the bus unless data arrives into an empty data queue
  stall_holds_bus: assert property (@(posedge clock) disable iff (rst)
    (proc2mem_command != BUS_NONE && mem2proc_response == '0 && (d_ready || !d_req.valid))
    |=> $stable(proc2mem_command) && $stable(proc2mem_addr) && $stable(proc2mem_data))
    else $error("bus changed during a stall");

  data_owns_bus: assert property (@(posedge clock) disable iff (rst)
    d_ready == (d_pending != '0))
    else $error("instruction side took the bus while data was pending");

  reply_gives_one_rsp: assert property (@(posedge clock) disable iff (rst)
    reply_hit |=> (i_rsp.valid != d_rsp.valid))
    else $error("load reply did not give exactly one response");

  one_reply_per_cycle: assert property (@(posedge clock) disable iff (rst)
    !reply_hit |=> !i_rsp.valid && !d_rsp.valid)
    else $error("response fired without a load reply");

endmodule

bind mem_port mem_port_assertions checks (
  .clock             (clock),
  .rst               (rst),
  .i_req             (i_req),
  .d_req             (d_req),
  .i_full            (i_full),
  .d_full            (d_full),
  .d_ready           (d_ready),
  .i_rsp             (i_rsp),
  .d_rsp             (d_rsp),
  .proc2mem_command  (proc2mem_command),
  .proc2mem_addr     (proc2mem_addr),
  .proc2mem_data     (proc2mem_data),
  .mem2proc_response (mem2proc_response),
  .mem2proc_tag      (mem2proc_tag)
);

// File: dv/mem_port_tb.sv
`include "mem_cfg.svh"

module mem_port_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import mem_pkg::*;

  localparam logic [`MEM_DATA_W-1:0] FILL = 64'h5a3c_96f0_0ff0_c3a5;
  localparam int N_OPS       = 14;
  localparam int MAX_STALL   = 8;
  localparam int MAX_DELAY   = 6;
  localparam int MAX_GAP     = 3;
  localparam int CYCLE_LIMIT = N_OPS * (MAX_STALL + MAX_DELAY + MAX_GAP) + 100;

  typedef struct packed {
    owner_e                 side;
    bus_cmd_e               cmd;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] data;
    logic [1:0]             gap;   // idle cycles after the strobe
  } op_t;

  typedef struct packed {
    owner_e   side;
    mem_rsp_t rsp;
  } pend_t;

  typedef struct packed {
    mem_tag_t               tag;
    logic [`MEM_DATA_W-1:0] data;
    logic [2:0]             delay;
  } reply_t;

  logic                   clock;
  logic                   rst;
  i_req_t                 i_req;
  d_req_t                 d_req;
  logic                   i_full;
  logic                   d_full;
  mem_rsp_t               i_rsp;
  mem_rsp_t               d_rsp;
  bus_cmd_e               proc2mem_command;
  logic [`MEM_ADDR_W-1:0] proc2mem_addr;
  logic [`MEM_DATA_W-1:0] proc2mem_data;
  mem_tag_t               mem2proc_response;
  logic [`MEM_DATA_W-1:0] mem2proc_data;
  mem_tag_t               mem2proc_tag;

  logic [31:0]            rng;
  int                     cycles;
  logic [`NUM_TAGS-1:0]   tag_busy;
  op_t                    i_issue_q [$];  // strobed and not yet accepted
  op_t                    d_issue_q [$];
  pend_t                  pend_q [$];
  reply_t                 inflight [$];
  logic [`MEM_DATA_W-1:0] mem_model [logic [`MEM_ADDR_W-1:0]];  // written at accept
  logic [`MEM_DATA_W-1:0] exp_mem [logic [`MEM_ADDR_W-1:0]];    // stepped in table order

  // instruction addresses are never stored
  op_t ops [N_OPS] = '{
    '{OWNER_I, BUS_LOAD,  64'h1000, 64'h0, 2'd0},
    '{OWNER_I, BUS_LOAD,  64'h1008, 64'h0, 2'd0},
    '{OWNER_D, BUS_LOAD,  64'h8000, 64'h0, 2'd0},  // fill value
    '{OWNER_D, BUS_STORE, 64'h8000, 64'h1111_2222_3333_4444, 2'd0},
    '{OWNER_D, BUS_LOAD,  64'h8000, 64'h0, 2'd0},  // sees the store
    '{OWNER_I, BUS_LOAD,  64'h1010, 64'h0, 2'd1},
    '{OWNER_D, BUS_STORE, 64'h8008, 64'hdead_beef_0000_0001, 2'd0},
    '{OWNER_D, BUS_STORE, 64'h8010, 64'hdead_beef_0000_0002, 2'd0},
    '{OWNER_D, BUS_LOAD,  64'h8008, 64'h0, 2'd0},
    '{OWNER_D, BUS_LOAD,  64'h8010, 64'h0, 2'd0},
    '{OWNER_D, BUS_LOAD,  64'h8018, 64'h0, 2'd0},
    '{OWNER_I, BUS_LOAD,  64'h1000, 64'h0, 2'd0},
    '{OWNER_I, BUS_LOAD,  64'h1018, 64'h0, 2'd2},
    '{OWNER_D, BUS_LOAD,  64'h8000, 64'h0, 2'd3}
  };

  mem_port dut (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rsp(input string name, input mem_rsp_t got, input mem_rsp_t exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL t=%0t %s expected %h got %h", $time, name, exp, got));
  endtask

  task automatic check_cmd(input string name, input bus_cmd_e got, input bus_cmd_e exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL t=%0t %s expected %s got %s", $time, name,
                              exp.name(), got.name()));
  endtask

  task automatic check_word(input string name, input logic [`MEM_ADDR_W-1:0] got,
                            input logic [`MEM_ADDR_W-1:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL t=%0t %s expected %h got %h", $time, name, exp, got));
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL t=%0t %s expected %b got %b", $time, name, exp, got));
  endtask

  // memory side of one cycle just after the edge
  task automatic memory_cycle();
    bus_cmd_e               exp_cmd;
    logic [`MEM_ADDR_W-1:0] exp_addr;
    logic [`MEM_DATA_W-1:0] exp_data;
    mem_tag_t               tag;
    mem_tag_t               freed;
    reply_t                 r;
    int                     ready_idx;
    int                     k;
    tag       = '0;
    freed     = '0;
    ready_idx = -1;
    exp_cmd   = BUS_NONE;
    exp_addr  = '0;
    exp_data  = '0;
    if (d_issue_q.size() != 0) begin  // data head owns the bus
      exp_cmd  = d_issue_q[0].cmd;
      exp_addr = d_issue_q[0].addr;
      exp_data = d_issue_q[0].data;
    end else if (i_issue_q.size() != 0) begin
      exp_cmd  = BUS_LOAD;
      exp_addr = i_issue_q[0].addr;
    end
    check_level("i_full", i_full, i_issue_q.size() == `MISS_DEPTH);
    check_level("d_full", d_full, d_issue_q.size() == `MISS_DEPTH);
    check_cmd("proc2mem_command", proc2mem_command, exp_cmd);
    if (exp_cmd != BUS_NONE) check_word("proc2mem_addr", proc2mem_addr, exp_addr);
    if (exp_cmd == BUS_STORE) check_word("proc2mem_data", proc2mem_data, exp_data);
    for (k = 0; k < inflight.size(); k++) begin
      if (inflight[k].delay != 0) inflight[k].delay = inflight[k].delay - 3'd1;
      if (inflight[k].delay == 0 && ready_idx < 0) ready_idx = k;
    end
    mem2proc_tag  = '0;
    mem2proc_data = '0;
    if (ready_idx >= 0) begin
      mem2proc_tag  = inflight[ready_idx].tag;
      mem2proc_data = inflight[ready_idx].data;
      freed         = inflight[ready_idx].tag;
      inflight.delete(ready_idx);
    end
    mem2proc_response = '0;
    rng = xorshift32(rng);
    if (proc2mem_command != BUS_NONE && rng[2:0] > 3'd2) begin  // about 3 in 8 stall
      for (k = 1; k < `NUM_TAGS; k++)
        if (!tag_busy[k] && tag == '0) tag = mem_tag_t'(k);
      mem2proc_response = tag;
    end
    if (mem2proc_response != '0) begin
      if (proc2mem_command == BUS_STORE) begin
        mem_model[proc2mem_addr] = proc2mem_data;
      end else begin
        rng        = xorshift32(rng);
        r.tag      = tag;
        r.data     = mem_model.exists(proc2mem_addr) ? mem_model[proc2mem_addr]
                                                     : proc2mem_addr ^ FILL;
        r.delay    = 3'(1 + (rng % MAX_DELAY));
        tag_busy[tag] = 1'b1;
        inflight.push_back(r);
      end
      if (d_issue_q.size() != 0) void'(d_issue_q.pop_front());
      else void'(i_issue_q.pop_front());
    end
    if (freed != '0) tag_busy[freed] = 1'b0;  // not reused in the cycle it returns
  endtask

  task automatic step_cycle();
    @(posedge clock);
    #1;
    i_req  = '0;  // strobes last one cycle
    d_req  = '0;
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) stop_on_error("timeout, run went past its cycle limit");
    memory_cycle();
  endtask

  task automatic apply_op(input op_t op);
    pend_t p;
    p.side      = op.side;
    p.rsp.valid = 1'b1;
    p.rsp.addr  = op.addr;
    if (op.side == OWNER_I) begin
      while (i_full) step_cycle();
      i_req = '{valid: 1'b1, addr: op.addr};
      i_issue_q.push_back(op);
      p.rsp.data = op.addr ^ FILL;
      pend_q.push_back(p);
    end else begin
      while (d_full) step_cycle();
      d_req = '{valid: 1'b1, cmd: op.cmd, addr: op.addr, data: op.data};
      d_issue_q.push_back(op);
      if (op.cmd == BUS_STORE) begin
        exp_mem[op.addr] = op.data;
      end else begin
        p.rsp.data = exp_mem.exists(op.addr) ? exp_mem[op.addr] : op.addr ^ FILL;
        pend_q.push_back(p);
      end
    end
    step_cycle();
    repeat (op.gap) step_cycle();
  endtask

  // match by address with data breaking ties between loads of one address
  task automatic match_rsp(input owner_e side, input string name, input mem_rsp_t got);
    int idx;
    int k;
    idx = -1;
    for (k = 0; k < pend_q.size(); k++)
      if (idx < 0 && pend_q[k].side == side && pend_q[k].rsp == got) idx = k;
    for (k = 0; k < pend_q.size(); k++)
      if (idx < 0 && pend_q[k].side == side && pend_q[k].rsp.addr == got.addr) idx = k;
    if (idx < 0) begin
      stop_on_error($sformatf("%s fired for address %h with no load pending", name, got.addr));
    end else begin
      check_rsp(name, got, pend_q[idx].rsp);
      pend_q.delete(idx);
    end
  endtask

  always @(negedge clock) begin
    if (!rst) begin
      if (i_rsp.valid) match_rsp(OWNER_I, "i_rsp", i_rsp);
      if (d_rsp.valid) match_rsp(OWNER_D, "d_rsp", d_rsp);
    end
  end

  initial begin
    rng               = 32'h56ae_603c;
    cycles            = 0;
    tag_busy          = '0;
    rst               = 1'b1;
    i_req             = '0;
    d_req             = '0;
    mem2proc_response = '0;
    mem2proc_data     = '0;
    mem2proc_tag      = '0;
    repeat (8) @(posedge clock);
    #1 rst = 1'b0;
    repeat (4) step_cycle();  // idle bus after reset
    foreach (ops[n]) apply_op(ops[n]);
    // wait until memory has accepted and answered everything
    while (inflight.size() != 0 || d_issue_q.size() != 0 || i_issue_q.size() != 0)
      step_cycle();
    repeat (10) step_cycle();  // last responses and any stray store response
    if (pend_q.size() != 0) begin
      stop_on_error("loads still pending at the end of the run");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

// File: list.f
+incdir+rtl
rtl/mem_pkg.sv
rtl/req_queue.sv
rtl/bus_arbiter.sv
rtl/tag_table.sv
rtl/mem_port.sv
dv/mem_port_assertions.sv
dv/mem_port_tb.sv

// File: run.sh
#!/bin/sh
# build and run the mem_port testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
PASS_MSG="Test completed successfully"

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module mem_port_tb -Mdir obj_dir -o mem_port_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/mem_port_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "$PASS_MSG" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
